// ==== common/mci_pkg.sv ====
// MCI shared definitions
// Bus types, memory map, register offsets, SRAM FSM states, byte merge

`include "mci_settings.svh"

package mci_pkg;

    typedef logic [`MCI_ADDR_W-1:0]   mci_addr_t;
    typedef logic [`MCI_DATA_W-1:0]   mci_data_t;
    typedef logic [`MCI_DATA_W/8-1:0] mci_strb_t;

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////
    localparam int        MCI_REG_OFF_W  = 12;
    localparam mci_addr_t MCI_REG_START  = mci_addr_t'(32'h0000_0000);
    localparam mci_addr_t MCI_REG_END    = MCI_REG_START + mci_addr_t'((1 << MCI_REG_OFF_W) - 1);
    localparam mci_addr_t MCU_SRAM_START = mci_addr_t'(32'h0002_0000);
    localparam mci_addr_t MCU_SRAM_END   = MCU_SRAM_START +
                                           mci_addr_t'(`MCU_SRAM_SIZE_KB * 1024 - 1);

    // SRAM geometry in words
    localparam int MCU_SRAM_DEPTH = `MCU_SRAM_SIZE_KB * 1024 / (`MCI_DATA_W / 8);
    localparam int MCU_SRAM_IDX_W = $clog2(MCU_SRAM_DEPTH);

    // Register offsets inside the register window
    typedef enum logic [MCI_REG_OFF_W-1:0] {
        MCI_REG_ID       = 12'h000,
        MCI_REG_SCRATCH0 = 12'h010,
        MCI_REG_SCRATCH1 = 12'h014,
        MCI_REG_SCRATCH2 = 12'h018,
        MCI_REG_SCRATCH3 = 12'h01C
    } mci_reg_offset_e;

    // SRAM access FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } mcu_sram_state_e;

    // Replace the strobed bytes of a word
    function automatic mci_data_t mci_byte_merge(mci_data_t cur_val, mci_data_t wr_val,
                                                 mci_strb_t strb);
        mci_data_t merged;
        merged = cur_val;
        for (int b = 0; b < $bits(mci_strb_t); b++) begin
            if (strb[b]) merged[8*b +: 8] = wr_val[8*b +: 8];
        end
        return merged;
    endfunction

endpackage

// ==== common/mci_settings.svh ====
// MCI subordinate build settings
// Bus widths, SRAM window size, SRAM wait states and the ID constant

`ifndef MCI_SETTINGS_SVH
`define MCI_SETTINGS_SVH

// Request address width in bits
`define MCI_ADDR_W 32

// Data width in bits, one strobe per byte
`define MCI_DATA_W 32

// MCU SRAM window size in kilobytes
`define MCU_SRAM_SIZE_KB 4

// SRAM wait states, legal range 1 to 15
`define MCU_SRAM_WAIT 2

// Read-only identification word
`define MCI_ID_VALUE 32'h4D43_4901

`endif

// ==== filelist.f ====
+incdir+common
common/mci_pkg.sv
rtl/mci_axi_sub_decode.sv
rtl/mci_reg.sv
mcu_sram/mcu_sram_ctrl.sv
mcu_sram/mci_wait_timer.sv
mcu_sram/mcu_sram_mem.sv
rtl/mci_sub_top.sv
tb/tb_clk_gen.sv
tb/tb_mci_sub.sv

// ==== mcu_sram/mci_wait_timer.sv ====
// SRAM wait timer
// Loadable down-counter that flags the cycle in which the count hits zero

`include "mci_settings.svh"

module mci_wait_timer
    import mci_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic load,
    output logic done
);

    logic [3:0] count;
    logic       running;

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= 4'(`MCU_SRAM_WAIT - 1);
            running <= 1'b1;
        end else if (running) begin
            // Stop after the zero cycle
            if (count == '0) running <= 1'b0;
            else             count   <= count - 4'd1;
        end
    end

    assign done = running & (count == '0);

endmodule

// ==== mcu_sram/mcu_sram_ctrl.sv ====
// MCU SRAM access controller
// Holds the requester through the wait period, issues the read when
// the timer expires and commits writes in the completion cycle

module mcu_sram_ctrl
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Request from the decoder
    input  logic      sram_dv,
    input  logic      write,
    input  mci_strb_t wstrb,

    // Response toward the decoder
    output logic      sram_hold,
    output logic      sram_error,

    // Wait timer
    output logic      timer_load,
    input  logic      timer_done,

    // Memory enables
    output logic      mem_rd_en,
    output logic      mem_wr_en
);

    mcu_sram_state_e state;
    mcu_sram_state_e state_nxt;
    logic            empty_strb;

    // Write with no byte lanes selected
    assign empty_strb = write & ~|wstrb;

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) state <= IDLE;
        else     state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (sram_dv) state_nxt = WAIT;
            WAIT:    if (timer_done) state_nxt = DONE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////
    // Stall from the first request cycle until DONE
    assign sram_hold  = ((state == IDLE) & sram_dv) | (state == WAIT);

    // Timer starts with the request
    assign timer_load = (state == IDLE) & sram_dv;

    // Read lands in the memory output register by DONE
    assign mem_rd_en  = (state == WAIT) & timer_done;

    assign mem_wr_en  = (state == DONE) & write & ~empty_strb;
    assign sram_error = (state == DONE) & empty_strb;

endmodule

// ==== mcu_sram/mcu_sram_mem.sv ====
// MCU SRAM storage
// Word array over the SRAM window, byte-strobe writes, registered read

module mcu_sram_mem
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rd_en,
    input  logic      wr_en,
    input  mci_addr_t addr,
    input  mci_data_t wdata,
    input  mci_strb_t wstrb,
    output mci_data_t rdata
);

    mci_addr_t                 win_off;
    logic [MCU_SRAM_IDX_W-1:0] word_idx;
    mci_data_t                 mem [MCU_SRAM_DEPTH];

    // Byte offset inside the window, then word index
    assign win_off  = addr - MCU_SRAM_START;
    assign word_idx = win_off[MCU_SRAM_IDX_W+1:2];

    //////////////////////////////////////////////////
    // Array access
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word_idx] <= mci_byte_merge(mem[word_idx], wdata, wstrb);
        end
    end

    // Data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

// ==== rtl/mci_axi_sub_decode.sv ====
// MCI request decoder
// Steers each request to the register block or the MCU SRAM by address
// window and merges rdata, hold and error back to the requester

module mci_axi_sub_decode
    import mci_pkg::*;
(
    // Requester side
    input  logic      dv,
    input  mci_addr_t addr,
    input  mci_data_t wdata,
    input  mci_strb_t wstrb,
    input  logic      write,
    output logic      hold,
    output mci_data_t rdata,
    output logic      error,

    // Shared request fields toward both targets
    output mci_addr_t req_addr,
    output mci_data_t req_wdata,
    output mci_strb_t req_wstrb,
    output logic      req_write,

    // Target selects
    output logic      reg_dv,
    output logic      sram_dv,

    // Target responses
    input  mci_data_t reg_rdata,
    input  logic      reg_error,
    input  logic      sram_hold,
    input  mci_data_t sram_rdata,
    input  logic      sram_error
);

    logic reg_gnt;
    logic sram_gnt;
    logic req_miss;

    //////////////////////////////////////////////////
    // Window decode
    //////////////////////////////////////////////////
    always_comb reg_gnt  = dv & (addr inside {[MCI_REG_START:MCI_REG_END]});
    always_comb sram_gnt = dv & (addr inside {[MCU_SRAM_START:MCU_SRAM_END]});

    // Neither window claims the access
    always_comb req_miss = dv & ~(reg_gnt | sram_gnt);

    // Only the matching target sees dv
    assign reg_dv  = reg_gnt;
    assign sram_dv = sram_gnt;

    // Same request payload to both targets
    assign req_addr  = addr;
    assign req_wdata = wdata;
    assign req_wstrb = wstrb;
    assign req_write = write;

    //////////////////////////////////////////////////
    // Response merge
    //////////////////////////////////////////////////
    // Zero data on a miss or with no request
    assign rdata = sram_gnt ? sram_rdata :
                   reg_gnt  ? reg_rdata  :
                   '0;

    // Register block never stalls
    assign hold = sram_gnt & sram_hold;

    assign error = (sram_gnt & sram_error) |
                   (reg_gnt  & reg_error)  |
                   req_miss;

endmodule

// ==== rtl/mci_reg.sv ====
// MCI register block
// ID constant and four scratch words, answered in the same cycle
// Flags undefined offsets, ID writes and unaligned addresses

`include "mci_settings.svh"

module mci_reg
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Request from the decoder
    input  logic      reg_dv,
    input  mci_addr_t addr,
    input  mci_data_t wdata,
    input  mci_strb_t wstrb,
    input  logic      write,

    // Combinational response
    output mci_data_t reg_rdata,
    output logic      reg_error
);

    logic [MCI_REG_OFF_W-1:0] word_off;
    logic [1:0]               scr_idx;
    logic                     unaligned;
    logic                     id_hit;
    logic                     scr_hit;
    logic                     scr_we;
    mci_data_t                rd_word;
    mci_data_t                scratch [4];

    // Decode on the word offset so byte lanes do not hide a misalignment
    assign word_off  = {addr[MCI_REG_OFF_W-1:2], 2'b00};
    assign scr_idx   = addr[3:2];
    assign unaligned = |addr[1:0];

    //////////////////////////////////////////////////
    // Offset decode and read mux
    //////////////////////////////////////////////////
    always_comb begin
        id_hit  = 1'b0;
        scr_hit = 1'b0;
        rd_word = '0;
        case (word_off)
            MCI_REG_ID: begin
                id_hit  = 1'b1;
                rd_word = `MCI_ID_VALUE;
            end
            MCI_REG_SCRATCH0, MCI_REG_SCRATCH1,
            MCI_REG_SCRATCH2, MCI_REG_SCRATCH3: begin
                scr_hit = 1'b1;
                rd_word = scratch[scr_idx];
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // Undefined offset, unaligned, or write to read-only ID
    assign reg_error = reg_dv & (unaligned | ~(id_hit | scr_hit) | (write & id_hit));

    // No data returned on a failed access
    assign reg_rdata = reg_error ? '0 : rd_word;

    // Faulting writes leave state untouched
    assign scr_we = reg_dv & write & scr_hit & ~reg_error;

    //////////////////////////////////////////////////
    // Scratch storage
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) scratch[i] <= '0;
        end else if (scr_we) begin
            scratch[scr_idx] <= mci_byte_merge(scratch[scr_idx], wdata, wstrb);
        end
    end

endmodule

// ==== rtl/mci_sub_top.sv ====
// MCI subordinate request path
// Decoder in front of the register block and the wait-stated MCU SRAM

module mci_sub_top
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Requester interface
    input  logic      dv,
    input  mci_addr_t addr,
    input  mci_data_t wdata,
    input  mci_strb_t wstrb,
    input  logic      write,
    output logic      hold,
    output mci_data_t rdata,
    output logic      error
);

    // Shared request fields
    mci_addr_t req_addr;
    mci_data_t req_wdata;
    mci_strb_t req_wstrb;
    logic      req_write;

    // Register block
    logic      reg_dv;
    mci_data_t reg_rdata;
    logic      reg_error;

    // SRAM path
    logic      sram_dv;
    logic      sram_hold;
    mci_data_t sram_rdata;
    logic      sram_error;
    logic      timer_load;
    logic      timer_done;
    logic      mem_rd_en;
    logic      mem_wr_en;

    mci_axi_sub_decode i_decode (
        .dv        (dv),         .addr      (addr),       .wdata      (wdata),
        .wstrb     (wstrb),      .write     (write),      .hold       (hold),
        .rdata     (rdata),      .error     (error),      .req_addr   (req_addr),
        .req_wdata (req_wdata),  .req_wstrb (req_wstrb),  .req_write  (req_write),
        .reg_dv    (reg_dv),     .sram_dv   (sram_dv),    .reg_rdata  (reg_rdata),
        .reg_error (reg_error),  .sram_hold (sram_hold),  .sram_rdata (sram_rdata),
        .sram_error(sram_error)
    );

    mci_reg i_reg (
        .clk       (clk),        .rst       (rst),        .reg_dv     (reg_dv),
        .addr      (req_addr),   .wdata     (req_wdata),  .wstrb      (req_wstrb),
        .write     (req_write),  .reg_rdata (reg_rdata),  .reg_error  (reg_error)
    );

    //////////////////////////////////////////////////
    // MCU SRAM path
    //////////////////////////////////////////////////
    mcu_sram_ctrl i_sram_ctrl (
        .clk       (clk),        .rst       (rst),        .sram_dv    (sram_dv),
        .write     (req_write),  .wstrb     (req_wstrb),  .sram_hold  (sram_hold),
        .sram_error(sram_error), .timer_load(timer_load), .timer_done (timer_done),
        .mem_rd_en (mem_rd_en),  .mem_wr_en (mem_wr_en)
    );

    mci_wait_timer i_wait_timer (
        .clk (clk),
        .rst (rst),
        .load(timer_load),
        .done(timer_done)
    );

    mcu_sram_mem i_sram_mem (
        .clk  (clk),        .rd_en(mem_rd_en),  .wr_en(mem_wr_en),
        .addr (req_addr),   .wdata(req_wdata),  .wstrb(req_wstrb),
        .rdata(sram_rdata)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
// Testbench clock source
// Free-running clock with a period of 4 time units

module tb_clk_gen (
    output logic clk
);

    // Half period of 2 units
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

// ==== tb/tb_mci_sub.sv ====
// MCI subordinate testbench
// Directed tests for registers, decode errors, SRAM data and SRAM wait timing

`include "mci_settings.svh"

module tb_mci_sub
    import mci_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        dv;
    mci_addr_t   addr;
    mci_data_t   wdata;
    mci_strb_t   wstrb;
    logic        write;
    logic        hold;
    mci_data_t   rdata;
    logic        error;

    int          error_cnt;
    int          timeout_cnt;
    logic [15:0] lfsr_state;
    mci_data_t   scr_model [4];
    mci_data_t   sram_model [5];

    tb_clk_gen i_clk_gen (.clk(clk));

    mci_sub_top i_mci_sub_top (
        .clk(clk),     .rst(rst),     .dv(dv),       .addr(addr),
        .wdata(wdata), .wstrb(wstrb), .write(write), .hold(hold),
        .rdata(rdata), .error(error)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Strobed bytes come from the new word
    function automatic mci_data_t apply_strobes(mci_data_t old_w, mci_data_t new_w,
                                                mci_strb_t st);
        mci_data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_word(input string tname, input logic [31:0] exp, act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h actual %h", tname, exp, act);
            error_cnt++;
        end
    endtask

    // Drive 1 unit after the edge, sample at the falling edge
    task automatic access(input logic wr, input mci_addr_t a, input mci_data_t wd,
                          input mci_strb_t st, output mci_data_t rd, output logic err,
                          output int hcnt);
        bit done;
        done = 1'b0;
        hcnt = 0;
        rd   = 'x;
        err  = 1'bx;
        @(posedge clk);
        #1;
        dv    = 1'b1;
        write = wr;
        addr  = a;
        wdata = wd;
        wstrb = st;
        for (int c = 0; c < 40 && !done; c++) begin
            @(negedge clk);
            if (hold) begin
                hcnt++;
            end else begin
                done = 1'b1;
                rd   = rdata;
                err  = error;
            end
        end
        if (!done) begin
            $display("Access to address %h timed out with hold still high", a);
            timeout_cnt++;
        end
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #1;
        dv    = 1'b0;
        write = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic reset_id_test();
        mci_data_t rd;
        logic      err;
        int        hc;
        access(1'b0, MCI_REG_START, '0, 4'hF, rd, err, hc);
        check_word("reset_id", `MCI_ID_VALUE, rd);
        check_word("reset_id", 32'd0, 32'(err));
        for (int i = 0; i < 4; i++) begin
            access(1'b0, MCI_REG_START + 32'h10 + 32'(4 * i), '0, 4'hF, rd, err, hc);
            check_word("reset_id", 32'd0, rd);
            check_word("reset_id", 32'd0, 32'(err));
        end
        bus_idle();
    endtask

    task automatic scratch_test();
        mci_data_t rd;
        mci_data_t wd;
        logic [31:0] st;
        logic      err;
        int        hc;
        // Two rounds so partial strobes land on written data
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 4; i++) begin
                take_bits(32, wd);
                take_bits(4, st);
                access(1'b1, 32'h10 + 32'(4 * i), wd, st[3:0], rd, err, hc);
                scr_model[i] = apply_strobes(scr_model[i], wd, st[3:0]);
                check_word("scratch", 32'd0, 32'(err));
                check_word("scratch", 32'd0, 32'(hc));
            end
        end
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 32'h10 + 32'(4 * i), '0, 4'hF, rd, err, hc);
            check_word("scratch", scr_model[i], rd);
            check_word("scratch", 32'd0, 32'(hc));
        end
        bus_idle();
    endtask

    task automatic error_test();
        mci_data_t rd;
        mci_data_t wd;
        logic      err;
        int        hc;
        // Gap between the windows
        access(1'b0, 32'h0001_0000, '0, 4'hF, rd, err, hc);
        check_word("err_miss", 32'd1, 32'(err));
        check_word("err_miss", 32'd0, rd);
        access(1'b0, 32'h0000_0020, '0, 4'hF, rd, err, hc);
        check_word("err_offset", 32'd1, 32'(err));
        take_bits(32, wd);
        access(1'b1, 32'h0000_0000, wd, 4'hF, rd, err, hc);
        check_word("err_id_write", 32'd1, 32'(err));
        access(1'b0, 32'h0000_0000, '0, 4'hF, rd, err, hc);
        check_word("err_id_write", `MCI_ID_VALUE, rd);
        access(1'b0, 32'h0000_0011, '0, 4'hF, rd, err, hc);
        check_word("err_unaligned", 32'd1, 32'(err));
        bus_idle();
    endtask

    task automatic sram_data_test();
        mci_data_t rd;
        mci_data_t wd;
        mci_addr_t a;
        logic [31:0] st;
        logic      err;
        int        hc;
        for (int k = 0; k < 5; k++) begin
            a = MCU_SRAM_START + 32'(k * 148);
            take_bits(32, wd);
            access(1'b1, a, wd, 4'hF, rd, err, hc);
            sram_model[k] = wd;
            check_word("sram_data", 32'd0, 32'(err));
            check_word("sram_timing", 32'(`MCU_SRAM_WAIT + 1), 32'(hc));
            // Partial strobe on top that is never empty
            take_bits(32, wd);
            take_bits(4, st);
            st[k % 4] = 1'b1;
            access(1'b1, a, wd, st[3:0], rd, err, hc);
            sram_model[k] = apply_strobes(sram_model[k], wd, st[3:0]);
            check_word("sram_timing", 32'(`MCU_SRAM_WAIT + 1), 32'(hc));
        end
        // Empty strobe write must fault and change nothing
        access(1'b1, MCU_SRAM_START, 32'hFFFF_FFFF, 4'h0, rd, err, hc);
        check_word("sram_empty_strb", 32'd1, 32'(err));
        for (int k = 0; k < 5; k++) begin
            access(1'b0, MCU_SRAM_START + 32'(k * 148), '0, 4'hF, rd, err, hc);
            check_word("sram_data", sram_model[k], rd);
            check_word("sram_timing", 32'(`MCU_SRAM_WAIT + 1), 32'(hc));
        end
        bus_idle();
    endtask

    task automatic back_to_back_test();
        mci_data_t rd;
        mci_data_t wd;
        logic      err;
        int        hc;
        take_bits(32, wd);
        access(1'b1, MCU_SRAM_START + 32'h40, wd, 4'hF, rd, err, hc);
        check_word("b2b", 32'(`MCU_SRAM_WAIT + 1), 32'(hc));
        access(1'b0, 32'h14, '0, 4'hF, rd, err, hc);
        check_word("b2b", scr_model[1], rd);
        check_word("b2b", 32'd0, 32'(hc));
        access(1'b0, MCU_SRAM_START + 32'h40, '0, 4'hF, rd, err, hc);
        check_word("b2b", wd, rd);
        access(1'b1, 32'h18, ~wd, 4'hF, rd, err, hc);
        scr_model[2] = ~wd;
        access(1'b0, MCU_SRAM_START + 32'(2 * 148), '0, 4'hF, rd, err, hc);
        check_word("b2b", sram_model[2], rd);
        access(1'b0, 32'h18, '0, 4'hF, rd, err, hc);
        check_word("b2b", scr_model[2], rd);
        check_word("b2b", 32'd0, 32'(err));
        bus_idle();
        // Hold stays down once the bus is quiet
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            check_word("b2b_hold", 32'd0, 32'(hold));
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        rst         = 1'b1;
        dv          = 1'b0;
        addr        = '0;
        wdata       = '0;
        wstrb       = '0;
        write       = 1'b0;
        error_cnt   = 0;
        timeout_cnt = 0;
        lfsr_state  = 16'd19504;
        for (int i = 0; i < 4; i++) begin
            scr_model[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_id_test();
        scratch_test();
        error_test();
        sram_data_test();
        back_to_back_test();

        $display("Run complete: %0d errors, %0d timeouts", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
